/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // ==================================================
  // address and line geometry
  // ==================================================
  localparam int VADDR_W       = 32;
  localparam int LINE_BYTES    = 16;
  localparam int LINE_W        = LINE_BYTES * 8;
  localparam int LINE_OFF_W    = $clog2(LINE_BYTES);      // byte offset inside a line
  localparam int INST_PER_LINE = 4;
  localparam int WORD_IDX_W    = $clog2(INST_PER_LINE);   // word index inside a line
  localparam int INST_OFF_W    = LINE_OFF_W - WORD_IDX_W; // byte offset inside a word

  typedef logic [VADDR_W-1:0]            vaddr_t;
  typedef logic [VADDR_W-LINE_OFF_W-1:0] line_addr_t;  // address with line offset removed
  typedef logic [LINE_W-1:0]             line_t;       // word k sits at bits [32k +: 32]
  typedef logic [31:0]                   inst_t;
  typedef logic [WORD_IDX_W-1:0]         word_idx_t;

  localparam word_idx_t LAST_WORD = WORD_IDX_W'(INST_PER_LINE - 1);

  // ==================================================
  // instruction cache
  // ==================================================
  localparam int IC_SETS    = 16;
  localparam int IC_INDEX_W = $clog2(IC_SETS);
  localparam int IC_TAG_LSB = LINE_OFF_W + IC_INDEX_W;
  localparam int IC_TAG_W   = VADDR_W - IC_TAG_LSB;

  typedef logic [IC_INDEX_W-1:0] ic_index_t;
  typedef logic [IC_TAG_W-1:0]   ic_tag_t;

  // ==================================================
  // fetch control
  // ==================================================
  localparam vaddr_t PC_INIT_VAL = 32'h0000_1000;

  // kind of the committed redirect, picks the target
  typedef enum logic [1:0] {
    NONE,
    MRET,
    ECALL_M
  } except_kind_t;

  typedef enum logic [1:0] {
    INIT,
    ISSUED,
    WAIT_RD,       // refill running, s0 closed
    WAIT_FB_FREE   // line dropped, wait for a free buffer slot
  } fetch_state_t;

endpackage

`default_nettype wire

/* rtl/fetch_pc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_ctrl (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_commit_valid,
  input  fetch_pkg::except_kind_t i_commit_except,
  input  fetch_pkg::vaddr_t       i_commit_pc,
  input  fetch_pkg::vaddr_t       i_csr_mepc,
  input  fetch_pkg::vaddr_t       i_csr_mtvec,
  input  logic                    i_s0_ready,
  input  logic                    i_s2_miss,
  input  fetch_pkg::vaddr_t       i_s2_miss_vaddr,
  input  logic                    i_s2_valid,
  input  fetch_pkg::vaddr_t       i_s2_vaddr,
  input  logic                    i_ib_ready,
  output logic                    o_s0_req_valid,
  output fetch_pkg::vaddr_t       o_s0_vaddr,
  output logic                    o_flush
);

  fetch_pkg::fetch_state_t r_state;
  fetch_pkg::fetch_state_t w_state_next;
  fetch_pkg::vaddr_t       r_pc;
  fetch_pkg::vaddr_t       w_pc_next;
  fetch_pkg::vaddr_t       w_redirect_pc;
  logic                    w_s2_drop;
  logic                    w_s0_fire;

  // start of the line after the one holding a
  function automatic fetch_pkg::vaddr_t next_line(input fetch_pkg::vaddr_t a);
    next_line = {a[fetch_pkg::VADDR_W-1:fetch_pkg::LINE_OFF_W] + 1'b1,
                 {fetch_pkg::LINE_OFF_W{1'b0}}};
  endfunction

  // ==================================================
  // redirect from commit
  // ==================================================
  always_comb begin
    case (i_commit_except)
      fetch_pkg::MRET:    w_redirect_pc = i_csr_mepc;
      fetch_pkg::ECALL_M: w_redirect_pc = i_csr_mtvec;
      fetch_pkg::NONE:    w_redirect_pc = i_commit_pc;
      default:            w_redirect_pc = i_commit_pc;
    endcase
  end

  assign o_flush   = i_commit_valid;          // every redirect flushes
  assign w_s2_drop = i_s2_valid & ~i_ib_ready; // buffer full, line lost

  // redirect target goes straight to s0, no bubble
  assign o_s0_vaddr = i_commit_valid ? w_redirect_pc : r_pc;

  always_comb begin
    if (i_commit_valid) begin
      o_s0_req_valid = 1'b1;
    end else begin
      case (r_state)
        fetch_pkg::ISSUED:       o_s0_req_valid = ~i_s2_miss & ~w_s2_drop;
        fetch_pkg::WAIT_RD:      o_s0_req_valid = 1'b1; // goes out once s0 reopens
        fetch_pkg::WAIT_FB_FREE: o_s0_req_valid = i_ib_ready;
        default:                 o_s0_req_valid = 1'b0;
      endcase
    end
  end

  assign w_s0_fire = o_s0_req_valid & i_s0_ready;

  // ==================================================
  // fetch FSM and PC
  // ==================================================
  always_comb begin
    w_state_next = r_state;
    w_pc_next    = r_pc;
    if (i_commit_valid) begin
      // accepted target moves on, otherwise retry it after the refill
      w_pc_next    = w_s0_fire ? next_line(w_redirect_pc) : w_redirect_pc;
      w_state_next = w_s0_fire ? fetch_pkg::ISSUED : fetch_pkg::WAIT_RD;
    end else begin
      case (r_state)
        fetch_pkg::INIT: begin
          w_state_next = fetch_pkg::ISSUED;
        end
        fetch_pkg::ISSUED: begin
          if (i_s2_miss) begin
            w_pc_next    = i_s2_miss_vaddr;
            w_state_next = fetch_pkg::WAIT_RD;
          end else if (w_s2_drop) begin
            w_pc_next    = i_s2_vaddr; // refetch the dropped line
            w_state_next = fetch_pkg::WAIT_FB_FREE;
          end else if (w_s0_fire) begin
            w_pc_next = next_line(r_pc);
          end
        end
        fetch_pkg::WAIT_RD,
        fetch_pkg::WAIT_FB_FREE: begin
          if (w_s0_fire) begin
            w_pc_next    = next_line(r_pc);
            w_state_next = fetch_pkg::ISSUED;
          end
        end
        default: begin
          w_state_next = fetch_pkg::INIT;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= fetch_pkg::INIT;
      r_pc    <= fetch_pkg::PC_INIT_VAL;
    end else begin
      r_state <= w_state_next;
      r_pc    <= w_pc_next;
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_icache.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_icache (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_flush,
  input  logic              i_s0_req_valid,
  input  fetch_pkg::vaddr_t i_s0_vaddr,
  output logic              o_s0_ready,
  output logic              o_s2_valid,
  output fetch_pkg::vaddr_t o_s2_vaddr,
  output fetch_pkg::line_t  o_s2_line,
  output logic              o_s2_miss,
  output fetch_pkg::vaddr_t o_s2_miss_vaddr,
  output logic              o_l2_req_valid,
  output fetch_pkg::vaddr_t o_l2_req_addr,
  input  logic              i_l2_req_ready,
  input  logic              i_l2_resp_valid,
  input  fetch_pkg::line_t  i_l2_resp_data
);

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_REQ,
    RF_WAIT
  } refill_state_t;

  // arrays
  fetch_pkg::ic_tag_t             r_tag_arr  [fetch_pkg::IC_SETS];
  fetch_pkg::line_t               r_data_arr [fetch_pkg::IC_SETS];
  logic [fetch_pkg::IC_SETS-1:0]  r_vld_arr;

  logic                 w_s0_fire;
  fetch_pkg::ic_index_t w_s0_index;

  logic                 r_s1_valid;
  fetch_pkg::vaddr_t    r_s1_vaddr;
  fetch_pkg::ic_tag_t   r_s1_tag;
  logic                 r_s1_tag_vld;
  fetch_pkg::line_t     r_s1_line;
  logic                 w_s1_hit;

  logic                 r_s2_valid;
  fetch_pkg::vaddr_t    r_s2_vaddr;
  logic                 r_s2_hit;
  fetch_pkg::line_t     r_s2_line;
  logic                 w_s2_miss;

  refill_state_t        r_rf_state;
  fetch_pkg::vaddr_t    r_rf_addr;
  fetch_pkg::ic_index_t w_rf_index;
  logic                 w_rf_write;

  // ==================================================
  // s0: index the arrays
  // ==================================================
  // s0 closes during a refill and in the cycle a miss shows up in s2
  assign o_s0_ready = (r_rf_state == RF_IDLE) & ~w_s2_miss;
  assign w_s0_fire  = i_s0_req_valid & o_s0_ready;
  assign w_s0_index = i_s0_vaddr[fetch_pkg::LINE_OFF_W +: fetch_pkg::IC_INDEX_W];

  // ==================================================
  // s1: tag compare
  // ==================================================
  assign w_s1_hit = r_s1_tag_vld &
                    (r_s1_tag == r_s1_vaddr[fetch_pkg::VADDR_W-1:fetch_pkg::IC_TAG_LSB]);

  // ==================================================
  // s2: hit data or miss
  // ==================================================
  assign w_s2_miss       = r_s2_valid & ~r_s2_hit & ~i_flush;
  assign o_s2_valid      = r_s2_valid & r_s2_hit & ~i_flush;
  assign o_s2_vaddr      = r_s2_vaddr;
  assign o_s2_line       = r_s2_line;
  assign o_s2_miss       = w_s2_miss;
  assign o_s2_miss_vaddr = r_s2_vaddr;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
    end else begin
      r_s1_valid <= w_s0_fire;                            // new request outlives the flush
      r_s2_valid <= r_s1_valid & ~i_flush & ~w_s2_miss;   // younger one dies behind a miss
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_s0_fire) begin
      r_s1_vaddr   <= i_s0_vaddr;
      r_s1_tag     <= r_tag_arr[w_s0_index];
      r_s1_tag_vld <= r_vld_arr[w_s0_index];
      r_s1_line    <= r_data_arr[w_s0_index];
    end
    r_s2_vaddr <= r_s1_vaddr;
    r_s2_hit   <= w_s1_hit;
    r_s2_line  <= r_s1_line;
  end

  // ==================================================
  // refill from L2
  // ==================================================
  assign o_l2_req_valid = (r_rf_state == RF_REQ);
  assign o_l2_req_addr  = r_rf_addr;
  assign w_rf_index     = r_rf_addr[fetch_pkg::LINE_OFF_W +: fetch_pkg::IC_INDEX_W];
  assign w_rf_write     = (r_rf_state == RF_WAIT) & i_l2_resp_valid;

  // flush is not looked at here, the line always lands
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rf_state <= RF_IDLE;
      r_vld_arr  <= '0;
    end else begin
      case (r_rf_state)
        RF_IDLE: begin
          if (w_s2_miss) begin
            r_rf_state <= RF_REQ;
          end
        end
        RF_REQ: begin
          if (i_l2_req_ready) begin
            r_rf_state <= RF_WAIT;
          end
        end
        RF_WAIT: begin
          if (i_l2_resp_valid) begin
            r_rf_state            <= RF_IDLE;
            r_vld_arr[w_rf_index] <= 1'b1;
          end
        end
        default: begin
          r_rf_state <= RF_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((r_rf_state == RF_IDLE) && w_s2_miss) begin
      r_rf_addr <= {r_s2_vaddr[fetch_pkg::VADDR_W-1:fetch_pkg::LINE_OFF_W],
                    {fetch_pkg::LINE_OFF_W{1'b0}}}; // line aligned
    end
    if (w_rf_write) begin
      r_tag_arr[w_rf_index]  <= r_rf_addr[fetch_pkg::VADDR_W-1:fetch_pkg::IC_TAG_LSB];
      r_data_arr[w_rf_index] <= i_l2_resp_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_inst_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_inst_buffer (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_flush,
  input  logic              i_line_valid,
  input  fetch_pkg::vaddr_t i_line_vaddr,
  input  fetch_pkg::line_t  i_line,
  output logic              o_ib_ready,
  output logic              o_disp_valid,
  output fetch_pkg::vaddr_t o_disp_pc,
  output fetch_pkg::inst_t  o_disp_inst,
  input  logic              i_disp_ready
);

  // two line entries in a head/tail pointer FIFO
  fetch_pkg::vaddr_t     r_ent_vaddr [2];
  fetch_pkg::line_t      r_ent_line  [2];
  logic                  r_head;
  logic                  r_tail;
  logic [1:0]            r_count;
  fetch_pkg::word_idx_t  r_word_ptr;   // next word of the head line

  // next line the buffer takes so order holds after a drop
  logic                  r_exp_valid;
  fetch_pkg::line_addr_t r_exp_line;

  fetch_pkg::line_addr_t w_in_line;
  fetch_pkg::line_t      w_head_line;
  fetch_pkg::word_idx_t  w_in_word;
  logic                  w_in_order;
  logic                  w_push;
  logic                  w_fire;
  logic                  w_pop;

  assign w_in_line  = i_line_vaddr[fetch_pkg::VADDR_W-1:fetch_pkg::LINE_OFF_W];
  assign w_in_word  = i_line_vaddr[fetch_pkg::LINE_OFF_W-1:fetch_pkg::INST_OFF_W];
  assign w_in_order = ~r_exp_valid | (w_in_line == r_exp_line);

  assign o_ib_ready = (r_count != 2'd2);                      // a slot is free
  assign w_push     = i_line_valid & o_ib_ready & w_in_order;  // stale lines fall away

  // ==================================================
  // dispatch side
  // ==================================================
  assign w_head_line  = r_ent_line[r_head];
  assign o_disp_valid = (r_count != 2'd0);
  assign o_disp_pc    = {r_ent_vaddr[r_head][fetch_pkg::VADDR_W-1:fetch_pkg::LINE_OFF_W],
                         r_word_ptr, {fetch_pkg::INST_OFF_W{1'b0}}};
  assign o_disp_inst  = w_head_line[r_word_ptr * $bits(fetch_pkg::inst_t) +:
                                    $bits(fetch_pkg::inst_t)];

  assign w_fire = o_disp_valid & i_disp_ready;
  assign w_pop  = w_fire & (r_word_ptr == fetch_pkg::LAST_WORD); // head line used up

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head      <= 1'b0;
      r_tail      <= 1'b0;
      r_count     <= 2'd0;
      r_word_ptr  <= '0;
      r_exp_valid <= 1'b0;
    end else if (i_flush) begin
      r_head      <= 1'b0;
      r_tail      <= 1'b0;
      r_count     <= 2'd0;
      r_exp_valid <= 1'b0; // anything after a redirect is in order
    end else begin
      if (w_push) begin
        r_tail      <= ~r_tail;
        r_exp_valid <= 1'b1;
      end
      if (w_pop) begin
        r_head <= ~r_head;
      end

      case ({w_push, w_pop})
        2'b10:   r_count <= r_count + 2'd1;
        2'b01:   r_count <= r_count - 2'd1;
        default: r_count <= r_count;
      endcase

      // a new head starts at the word its address points to
      if (w_pop) begin
        if (r_count == 2'd2) begin
          r_word_ptr <= r_ent_vaddr[~r_head][fetch_pkg::LINE_OFF_W-1:fetch_pkg::INST_OFF_W];
        end else if (w_push) begin
          r_word_ptr <= w_in_word;
        end
      end else if (w_push && (r_count == 2'd0)) begin
        r_word_ptr <= w_in_word;
      end else if (w_fire) begin
        r_word_ptr <= r_word_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_ent_vaddr[r_tail] <= i_line_vaddr;
      r_ent_line[r_tail]  <= i_line;
      r_exp_line          <= w_in_line + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/fetch_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  // redirect from commit
  input  logic                    i_commit_valid,
  input  fetch_pkg::except_kind_t i_commit_except,
  input  fetch_pkg::vaddr_t       i_commit_pc,
  input  fetch_pkg::vaddr_t       i_csr_mepc,
  input  fetch_pkg::vaddr_t       i_csr_mtvec,

  // dispatch
  output logic                    o_disp_valid,
  output fetch_pkg::vaddr_t       o_disp_pc,
  output fetch_pkg::inst_t        o_disp_inst,
  input  logic                    i_disp_ready,

  // L2 refill port
  output logic                    o_l2_req_valid,
  output fetch_pkg::vaddr_t       o_l2_req_addr,
  input  logic                    i_l2_req_ready,
  input  logic                    i_l2_resp_valid,
  input  fetch_pkg::line_t        i_l2_resp_data
);

  logic              w_s0_req_valid;
  fetch_pkg::vaddr_t w_s0_vaddr;
  logic              w_s0_ready;
  logic              w_s2_miss;
  fetch_pkg::vaddr_t w_s2_miss_vaddr;
  logic              w_s2_valid;
  fetch_pkg::vaddr_t w_s2_vaddr;
  fetch_pkg::line_t  w_s2_line;
  logic              w_ib_ready;
  logic              w_flush;

  fetch_pc_ctrl u_pc_ctrl (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_commit_valid  (i_commit_valid),
    .i_commit_except (i_commit_except),
    .i_commit_pc     (i_commit_pc),
    .i_csr_mepc      (i_csr_mepc),
    .i_csr_mtvec     (i_csr_mtvec),
    .i_s0_ready      (w_s0_ready),
    .i_s2_miss       (w_s2_miss),
    .i_s2_miss_vaddr (w_s2_miss_vaddr),
    .i_s2_valid      (w_s2_valid),
    .i_s2_vaddr      (w_s2_vaddr),
    .i_ib_ready      (w_ib_ready),
    .o_s0_req_valid  (w_s0_req_valid),
    .o_s0_vaddr      (w_s0_vaddr),
    .o_flush         (w_flush)
  );

  fetch_icache u_icache (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_flush         (w_flush),
    .i_s0_req_valid  (w_s0_req_valid),
    .i_s0_vaddr      (w_s0_vaddr),
    .o_s0_ready      (w_s0_ready),
    .o_s2_valid      (w_s2_valid),
    .o_s2_vaddr      (w_s2_vaddr),
    .o_s2_line       (w_s2_line),
    .o_s2_miss       (w_s2_miss),
    .o_s2_miss_vaddr (w_s2_miss_vaddr),
    .o_l2_req_valid  (o_l2_req_valid),
    .o_l2_req_addr   (o_l2_req_addr),
    .i_l2_req_ready  (i_l2_req_ready),
    .i_l2_resp_valid (i_l2_resp_valid),
    .i_l2_resp_data  (i_l2_resp_data)
  );

  // hit lines feed the buffer, full buffer drops them
  fetch_inst_buffer u_inst_buffer (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (w_flush),
    .i_line_valid (w_s2_valid),
    .i_line_vaddr (w_s2_vaddr),
    .i_line       (w_s2_line),
    .o_ib_ready   (w_ib_ready),
    .o_disp_valid (o_disp_valid),
    .o_disp_pc    (o_disp_pc),
    .o_disp_inst  (o_disp_inst),
    .i_disp_ready (i_disp_ready)
  );

endmodule

`default_nettype wire

/* verification/fetch_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_checker #(
  parameter logic [31:0] MEM_PATTERN = 32'hA5A5_0000
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_test_start,  // clears the per-test counts
  input  fetch_pkg::vaddr_t       i_range_lo,
  input  fetch_pkg::vaddr_t       i_range_hi,
  input  logic                    i_commit_valid,
  input  fetch_pkg::except_kind_t i_commit_except,
  input  fetch_pkg::vaddr_t       i_commit_pc,
  input  fetch_pkg::vaddr_t       i_csr_mepc,
  input  fetch_pkg::vaddr_t       i_csr_mtvec,
  input  logic                    i_disp_valid,
  input  fetch_pkg::vaddr_t       i_disp_pc,
  input  fetch_pkg::inst_t        i_disp_inst,
  input  logic                    i_disp_ready,
  input  logic                    i_l2_req_valid,
  input  fetch_pkg::vaddr_t       i_l2_req_addr,
  input  logic                    i_l2_req_ready,
  output int                      o_consumed,
  output int                      o_l2_reqs,
  output int                      o_l2_in_range,
  output int                      o_errors
);

  fetch_pkg::vaddr_t r_exp_pc;     // next pc dispatch should hand out
  logic              r_held;       // offered last cycle but not taken
  fetch_pkg::vaddr_t r_held_pc;
  fetch_pkg::inst_t  r_held_inst;

  // word the memory holds at pc
  function automatic fetch_pkg::inst_t ref_inst(input fetch_pkg::vaddr_t pc);
    ref_inst = pc ^ MEM_PATTERN;
  endfunction

  // where a committed redirect resumes
  function automatic fetch_pkg::vaddr_t ref_target(input fetch_pkg::except_kind_t kind,
                                                   input fetch_pkg::vaddr_t pc,
                                                   input fetch_pkg::vaddr_t mepc,
                                                   input fetch_pkg::vaddr_t mtvec);
    case (kind)
      fetch_pkg::MRET:    ref_target = mepc;
      fetch_pkg::ECALL_M: ref_target = mtvec;
      default:            ref_target = pc;
    endcase
  endfunction

  always @(posedge i_clk or negedge i_reset_n) begin : compare
    fetch_pkg::vaddr_t next_exp;
    int                n_err;
    if (!i_reset_n) begin
      r_exp_pc      <= fetch_pkg::PC_INIT_VAL;
      r_held        <= 1'b0;
      o_consumed    <= 0;
      o_l2_reqs     <= 0;
      o_l2_in_range <= 0;
      o_errors      <= 0;
    end else begin
      next_exp = r_exp_pc;
      n_err    = 0;
      if (r_held && (!i_disp_valid || i_disp_pc !== r_held_pc ||
                     i_disp_inst !== r_held_inst)) begin
        $display("mismatch at %0t: dispatch changed while stalled, pc %h was %h",
                 $time, i_disp_pc, r_held_pc);
        n_err++;
      end
      if (i_disp_valid && i_disp_ready) begin
        if (i_disp_pc !== r_exp_pc) begin
          $display("mismatch at %0t: dispatch pc %h, expected %h", $time, i_disp_pc, r_exp_pc);
          n_err++;
        end
        if (i_disp_inst !== ref_inst(r_exp_pc)) begin
          $display("mismatch at %0t: inst %h at pc %h, expected %h",
                   $time, i_disp_inst, r_exp_pc, ref_inst(r_exp_pc));
          n_err++;
        end
        next_exp = r_exp_pc + 32'd4;
      end
      // redirect wins over the sequential step
      if (i_commit_valid) begin
        next_exp = ref_target(i_commit_except, i_commit_pc, i_csr_mepc, i_csr_mtvec);
      end

      r_exp_pc    <= next_exp;
      r_held      <= i_disp_valid & ~i_disp_ready & ~i_commit_valid;
      r_held_pc   <= i_disp_pc;
      r_held_inst <= i_disp_inst;
      o_errors    <= o_errors + n_err;

      if (i_test_start) begin
        o_consumed    <= 0;
        o_l2_reqs     <= 0;
        o_l2_in_range <= 0;
      end else begin
        o_consumed <= o_consumed + int'(i_disp_valid && i_disp_ready);
        if (i_l2_req_valid && i_l2_req_ready) begin
          o_l2_reqs <= o_l2_reqs + 1;
          if (i_l2_req_addr >= i_range_lo && i_l2_req_addr < i_range_hi) begin
            o_l2_in_range <= o_l2_in_range + 1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verification/tb_fetch_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

  localparam int          CLK_PERIOD    = 4;
  localparam logic [31:0] MEM_PATTERN   = 32'hA5A5_0000;
  localparam logic [31:0] LFSR_SEED     = 32'h1b08;
  localparam int          RUNAHEAD_SETS = 4;  // sets fetch run-ahead may overwrite past a window
  localparam int          TEST_LEN_SUM  = 64 + 64 + 200 + 16 + 8 + 8 + 8;
  localparam int          TIMEOUT_CYC   = TEST_LEN_SUM * 20;

  logic                    i_clk;
  logic                    i_reset_n;
  logic                    i_commit_valid;
  fetch_pkg::except_kind_t i_commit_except;
  fetch_pkg::vaddr_t       i_commit_pc;
  fetch_pkg::vaddr_t       i_csr_mepc;
  fetch_pkg::vaddr_t       i_csr_mtvec;
  logic                    o_disp_valid;
  fetch_pkg::vaddr_t       o_disp_pc;
  fetch_pkg::inst_t        o_disp_inst;
  logic                    i_disp_ready;
  logic                    o_l2_req_valid;
  fetch_pkg::vaddr_t       o_l2_req_addr;
  logic                    i_l2_req_ready;
  logic                    i_l2_resp_valid;
  fetch_pkg::line_t        i_l2_resp_data;

  logic              test_start;
  fetch_pkg::vaddr_t range_lo;
  fetch_pkg::vaddr_t range_hi;
  int                ready_mode;   // 0 low, 1 high, 2 random
  logic              slow_l2;
  logic [31:0]       lfsr_q;
  int                consumed;
  int                l2_reqs;
  int                l2_in_range;
  int                errors;
  int                tests_run;
  int                tests_failed;

  initial i_clk = 1'b0;
  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  fetch_frontend DUT (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_commit_valid  (i_commit_valid),
    .i_commit_except (i_commit_except),
    .i_commit_pc     (i_commit_pc),
    .i_csr_mepc      (i_csr_mepc),
    .i_csr_mtvec     (i_csr_mtvec),
    .o_disp_valid    (o_disp_valid),
    .o_disp_pc       (o_disp_pc),
    .o_disp_inst     (o_disp_inst),
    .i_disp_ready    (i_disp_ready),
    .o_l2_req_valid  (o_l2_req_valid),
    .o_l2_req_addr   (o_l2_req_addr),
    .i_l2_req_ready  (i_l2_req_ready),
    .i_l2_resp_valid (i_l2_resp_valid),
    .i_l2_resp_data  (i_l2_resp_data)
  );

  fetch_checker #(.MEM_PATTERN(MEM_PATTERN)) u_checker (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_test_start    (test_start),
    .i_range_lo      (range_lo),
    .i_range_hi      (range_hi),
    .i_commit_valid  (i_commit_valid),
    .i_commit_except (i_commit_except),
    .i_commit_pc     (i_commit_pc),
    .i_csr_mepc      (i_csr_mepc),
    .i_csr_mtvec     (i_csr_mtvec),
    .i_disp_valid    (o_disp_valid),
    .i_disp_pc       (o_disp_pc),
    .i_disp_inst     (o_disp_inst),
    .i_disp_ready    (i_disp_ready),
    .i_l2_req_valid  (o_l2_req_valid),
    .i_l2_req_addr   (o_l2_req_addr),
    .i_l2_req_ready  (i_l2_req_ready),
    .o_consumed      (consumed),
    .o_l2_reqs       (l2_reqs),
    .o_l2_in_range   (l2_in_range),
    .o_errors        (errors)
  );

  // ==================================================
  // random bits and memory contents
  // ==================================================
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[6:0], lfsr_q[0]};
    end
  endtask

  function automatic fetch_pkg::line_t line_of(input fetch_pkg::vaddr_t addr);
    line_of = '0;
    for (int k = 0; k < fetch_pkg::INST_PER_LINE; k++) begin
      line_of[32*k +: 32] = (addr + 32'(4 * k)) ^ MEM_PATTERN;
    end
  endfunction

  // dispatch ready and L2 model in one process, keeps the LFSR order fixed
  initial begin : env
    logic              req_seen;
    logic              slow;
    logic [7:0]        bits;
    int                mode;
    int                resp_wait;
    fetch_pkg::vaddr_t resp_addr;
    resp_wait = 0;
    resp_addr = '0;
    forever begin
      @(posedge i_clk);
      req_seen = i_reset_n & o_l2_req_valid & i_l2_req_ready;
      mode     = ready_mode;
      slow     = slow_l2;
      if (req_seen) begin
        resp_addr = o_l2_req_addr;
      end
      #1;
      i_l2_resp_valid = 1'b0;
      if (resp_wait > 0) begin
        resp_wait--;
        if (resp_wait == 0) begin
          i_l2_resp_valid = 1'b1;
          i_l2_resp_data  = line_of(resp_addr);
        end
      end
      if (req_seen) begin
        take_bits(3, bits);
        resp_wait = slow ? 8 : int'(bits[2:0]) + 1; // 1 to 8 cycles
      end
      take_bits(1, bits);
      i_l2_req_ready = bits[0];
      if (mode == 2) begin
        take_bits(1, bits);
        i_disp_ready = bits[0];
      end else begin
        i_disp_ready = (mode == 1);
      end
    end
  end

  // ==================================================
  // test steps
  // ==================================================
  task automatic start_test(input fetch_pkg::vaddr_t lo, input int n);
    range_lo   = lo;
    range_hi   = lo + 32'(4 * n);
    test_start = 1'b1;
    @(posedge i_clk);
    #1;
    test_start = 1'b0;
  endtask

  task automatic redirect(input fetch_pkg::except_kind_t kind, input fetch_pkg::vaddr_t pc);
    i_commit_valid  = 1'b1;
    i_commit_except = kind;
    i_commit_pc     = pc;
    @(posedge i_clk);
    #1;
    i_commit_valid  = 1'b0;
    i_commit_except = fetch_pkg::NONE;
  endtask

  task automatic wait_consumed(input int n);
    while (consumed < n) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic wait_l2_transfer(input fetch_pkg::vaddr_t addr);
    do begin
      @(posedge i_clk);
    end while (!(o_l2_req_valid && i_l2_req_ready && o_l2_req_addr == addr));
    #1;
  endtask

  task automatic finish_test(input string name, input int err_mark, input bit extra_ok);
    bit ok;
    ready_mode = 0;
    ok         = extra_ok && (errors == err_mark);
    tests_run++;
    if (!ok) begin
      tests_failed++;
    end
    $display("%s: %0d instructions, %0d L2 requests, %s",
             name, consumed, l2_reqs, ok ? "ok" : "failed");
  endtask

  initial begin : main
    int err_mark;
    bit ok;
    i_reset_n       = 1'b0;
    i_commit_valid  = 1'b0;
    i_commit_except = fetch_pkg::NONE;
    i_commit_pc     = '0;
    i_csr_mepc      = 32'h0000_4004;
    i_csr_mtvec     = 32'h0000_5000;
    i_disp_ready    = 1'b0;
    i_l2_req_ready  = 1'b0;
    i_l2_resp_valid = 1'b0;
    i_l2_resp_data  = '0;
    test_start      = 1'b0;
    range_lo        = '0;
    range_hi        = '0;
    ready_mode      = 0;
    slow_l2         = 1'b0;
    lfsr_q          = LFSR_SEED;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (5) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;

    err_mark = errors;  // cold fetch from the reset pc
    start_test(fetch_pkg::PC_INIT_VAL, 64);
    ready_mode = 1;
    wait_consumed(64);
    finish_test("test 1 cold fetch", err_mark, 1'b1);

    // warm refetch, only lines overwritten by run-ahead may refill
    err_mark = errors;
    start_test(fetch_pkg::PC_INIT_VAL, 64);
    ready_mode = 1;
    redirect(fetch_pkg::NONE, fetch_pkg::PC_INIT_VAL);
    wait_consumed(64);
    ok = (l2_in_range <= RUNAHEAD_SETS);
    if (!ok) begin
      $display("test 2: %0d lines refilled from L2, the cached lines did not hit", l2_in_range);
    end
    finish_test("test 2 warm refetch", err_mark, ok);

    err_mark = errors;  // carries on from the end of test 2
    start_test(fetch_pkg::PC_INIT_VAL + 32'h100, 200);
    ready_mode = 2;
    wait_consumed(200);
    finish_test("test 3 random dispatch ready", err_mark, 1'b1);

    err_mark = errors;
    start_test(32'h0000_3008, 16);
    ready_mode = 1;
    redirect(fetch_pkg::NONE, 32'h0000_3008); // word 2 of its line
    wait_consumed(16);
    finish_test("test 4 redirect mid line", err_mark, 1'b1);

    err_mark = errors;
    start_test(i_csr_mepc, 8);
    ready_mode = 1;
    redirect(fetch_pkg::MRET, 32'h0000_6000);
    wait_consumed(8);
    finish_test("test 5a mret to mepc", err_mark, 1'b1);

    err_mark = errors;
    start_test(i_csr_mtvec, 8);
    ready_mode = 1;
    redirect(fetch_pkg::ECALL_M, 32'h0000_6010);
    wait_consumed(8);
    finish_test("test 5b ecall to mtvec", err_mark, 1'b1);

    // second redirect lands while the first refill waits on L2
    err_mark = errors;
    slow_l2  = 1'b1;
    start_test(32'h0000_8040, 8);
    ready_mode = 1;
    redirect(fetch_pkg::NONE, 32'h0000_7000);
    wait_l2_transfer(32'h0000_7000);
    redirect(fetch_pkg::NONE, 32'h0000_8040);
    wait_consumed(8);
    slow_l2 = 1'b0;
    finish_test("test 6 redirect during refill", err_mark, 1'b1);

    $display("tests run %0d, tests failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
rtl/fetch_pkg.sv
rtl/fetch_pc_ctrl.sv
rtl/fetch_icache.sv
rtl/fetch_inst_buffer.sv
rtl/fetch_frontend.sv
verification/fetch_checker.sv
verification/tb_fetch_frontend.sv
